/* decodePkg.sv */
package decodePkg;

    // Machine widths fixed by RV32I
    localparam int xlen    = 32;
    localparam int regIdxW = 5;

    typedef logic [xlen-1:0]    wordT;   // Instruction, pc or immediate
    typedef logic [regIdxW-1:0] regIdxT; // Architectural register number
    typedef logic [6:0]         opcodeT;

    // Major opcodes, instruction bits 6:0
    localparam opcodeT opR      = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opFence  = 7'b0001111;
    localparam opcodeT opSystem = 7'b1110011;

    // ALU funct3 codes shared by R-type and I-type
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Sr     = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000; // SUB and SRA

    // Execute stage relies on these codes
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9,
        aluBeq  = 4'd10,
        aluBne  = 4'd11,
        aluBlt  = 4'd12,
        aluBge  = 4'd13,
        aluBltu = 4'd14,
        aluBgeu = 4'd15
    } aluOpT;

    typedef enum logic [1:0] {
        memNone     = 2'd0,
        memReadSext = 2'd1,
        memReadZext = 2'd2,
        memWrite    = 2'd3
    } memOpT;

    // Encoding matches funct3 bits 1:0 of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeT;

    // ALU operand B source
    typedef enum logic [1:0] {
        selBReg  = 2'd0,
        selBImm  = 2'd1,
        selBFour = 2'd2 // Link address pc + 4
    } selBT;

    typedef enum logic [2:0] {
        immNone   = 3'd0,
        immI      = 3'd1,
        immIShift = 3'd2,
        immS      = 3'd3,
        immB      = 3'd4,
        immU      = 3'd5,
        immJ      = 3'd6
    } immFmtT;

    typedef struct packed {
        aluOpT   aluOp;
        logic    selA;     // 0 rs1, 1 pc
        selBT    selB;
        logic    aluToReg; // ALU result written back to rd
        memOpT   memOp;
        memSizeT memSize;
        logic    branch;
        logic    jal;
        logic    jalr;
    } ctrlT;

    // All zero is a bubble
    typedef struct packed {
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   imm;
        wordT   pc;
        ctrlT   ctrl;
    } decodedT;

endpackage

/* immGen.sv */
`timescale 1ns/10ps

module immGen (
    input  decodePkg::wordT   instr,
    input  decodePkg::immFmtT immFmt,
    output decodePkg::wordT   imm
);
    import decodePkg::*;

    logic sign;

    assign sign = instr[31]; // Every signed format takes its sign from bit 31

    always_comb begin
        case (immFmt)
            immI: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            immIShift: begin
                // Shift amount only, zero extended
                imm = {26'b0, instr[25:20]};
            end
            immS: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                // Halfword aligned branch offset
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            immU: begin
                imm = {instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            immNone: begin
                imm = '0;
            end
            default: begin
                imm = '0; // Unused format codes
            end
        endcase
    end

endmodule

/* ctrlDecoder.sv */
`timescale 1ns/10ps

module ctrlDecoder (
    input  decodePkg::wordT   instr,
    output decodePkg::ctrlT   ctrl,
    output decodePkg::regIdxT rs1,
    output decodePkg::regIdxT rs2,
    output decodePkg::regIdxT rd,
    output decodePkg::immFmtT immFmt
);
    import decodePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;       // Instruction bit 30, selects SUB and SRA
    logic       rFunct7Ok;

    aluOpT      aluFn;     // R and I ALU operation from funct3
    aluOpT      brFn;
    logic       brOk;

    ctrlT       ctrlRaw;
    immFmtT     fmtRaw;
    logic       useRs1;
    logic       useRs2;
    logic       useRd;
    logic       legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = instr[30];

    // Only ADD/SUB and shift right have an alternate R-type form
    assign rFunct7Ok = (funct7 == f7Base) ||
                       ((funct7 == f7Alt) && ((funct3 == f3AddSub) || (funct3 == f3Sr)));

    always_comb begin
        case (funct3)
            f3AddSub: aluFn = (alt && (opcode == opR)) ? aluSub : aluAdd; // ADDI has no SUB
            f3Sll:    aluFn = aluSll;
            f3Slt:    aluFn = aluSlt;
            f3Sltu:   aluFn = aluSltu;
            f3Xor:    aluFn = aluXor;
            f3Sr:     aluFn = alt ? aluSra : aluSrl;
            f3Or:     aluFn = aluOr;
            f3And:    aluFn = aluAnd;
            default:  aluFn = aluAdd;
        endcase
    end

    // Branch comparisons
    always_comb begin
        brOk = 1'b1;
        case (funct3)
            3'b000:  brFn = aluBeq;
            3'b001:  brFn = aluBne;
            3'b100:  brFn = aluBlt;
            3'b101:  brFn = aluBge;
            3'b110:  brFn = aluBltu;
            3'b111:  brFn = aluBgeu;
            default: begin
                brFn = aluBeq;
                brOk = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrlRaw = '0;
        fmtRaw  = immNone;
        useRs1  = 1'b0;
        useRs2  = 1'b0;
        useRd   = 1'b0;
        legal   = 1'b1;

        case (opcode)
            opR: begin
                ctrlRaw.aluOp    = aluFn;
                ctrlRaw.selB     = selBReg;
                ctrlRaw.aluToReg = 1'b1;
                useRs1           = 1'b1;
                useRs2           = 1'b1;
                useRd            = 1'b1;
                legal            = rFunct7Ok;
            end
            opImm: begin
                ctrlRaw.aluOp    = aluFn;
                ctrlRaw.selB     = selBImm;
                ctrlRaw.aluToReg = 1'b1;
                fmtRaw           = ((funct3 == f3Sll) || (funct3 == f3Sr)) ? immIShift : immI;
                useRs1           = 1'b1;
                useRd            = 1'b1;
            end
            opLoad: begin
                // Address is rs1 + imm, data returns through the memory path
                ctrlRaw.aluOp   = aluAdd;
                ctrlRaw.selB    = selBImm;
                ctrlRaw.memOp   = funct3[2] ? memReadZext : memReadSext;
                ctrlRaw.memSize = memSizeT'(funct3[1:0]);
                fmtRaw          = immI;
                useRs1          = 1'b1;
                useRd           = 1'b1;
                legal           = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            opStore: begin
                ctrlRaw.aluOp   = aluAdd;
                ctrlRaw.selB    = selBImm;
                ctrlRaw.memOp   = memWrite;
                ctrlRaw.memSize = memSizeT'(funct3[1:0]);
                fmtRaw          = immS;
                useRs1          = 1'b1;
                useRs2          = 1'b1; // Store data
                legal           = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            opBranch: begin
                ctrlRaw.aluOp  = brFn;
                ctrlRaw.selB   = selBReg;
                ctrlRaw.branch = 1'b1;
                fmtRaw         = immB;
                useRs1         = 1'b1;
                useRs2         = 1'b1;
                legal          = brOk;
            end
            opJal: begin
                // ALU produces the link value pc + 4
                ctrlRaw.aluOp    = aluAdd;
                ctrlRaw.selA     = 1'b1;
                ctrlRaw.selB     = selBFour;
                ctrlRaw.aluToReg = 1'b1;
                ctrlRaw.jal      = 1'b1;
                fmtRaw           = immJ;
                useRd            = 1'b1;
            end
            opJalr: begin
                ctrlRaw.aluOp    = aluAdd;
                ctrlRaw.selA     = 1'b1;
                ctrlRaw.selB     = selBFour;
                ctrlRaw.aluToReg = 1'b1;
                ctrlRaw.jalr     = 1'b1;
                fmtRaw           = immI;
                useRs1           = 1'b1; // Jump base
                useRd            = 1'b1;
                legal            = (funct3 == 3'b000);
            end
            opLui: begin
                // Computed as x0 + imm
                ctrlRaw.aluOp    = aluAdd;
                ctrlRaw.selB     = selBImm;
                ctrlRaw.aluToReg = 1'b1;
                fmtRaw           = immU;
                useRd            = 1'b1;
            end
            opAuipc: begin
                ctrlRaw.aluOp    = aluAdd;
                ctrlRaw.selA     = 1'b1;
                ctrlRaw.selB     = selBImm;
                ctrlRaw.aluToReg = 1'b1;
                fmtRaw           = immU;
                useRd            = 1'b1;
            end
            opFence, opSystem: begin
                legal = 1'b0; // No side effects in this pipeline
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Any illegal pattern leaves every field at zero
    assign ctrl   = legal ? ctrlRaw : '0;
    assign immFmt = legal ? fmtRaw : immNone;
    assign rs1    = (legal && useRs1) ? instr[19:15] : '0;
    assign rs2    = (legal && useRs2) ? instr[24:20] : '0;
    assign rd     = (legal && useRd) ? instr[11:7] : '0;

endmodule

/* decodeStageReg.sv */
`timescale 1ns/10ps

module decodeStageReg (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  decodePkg::decodedT next,
    output decodePkg::decodedT decoded
);

    // Set by flush, the instruction arriving after it is wrong-path
    logic discardNext;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decoded     <= '0;
            discardNext <= 1'b0;
        end else if (flush) begin
            // Bubble now and drop the next unstalled instruction
            decoded     <= '0;
            discardNext <= 1'b1;
        end else if (!stall) begin
            if (discardNext) begin
                discardNext <= 1'b0; // Output keeps the bubble
            end else begin
                decoded <= next;
            end
        end
        // Stall holds both the output and the pending discard
    end

endmodule

/* decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  decodePkg::wordT    instr,
    input  decodePkg::wordT    pcIn,
    output decodePkg::decodedT decoded
);
    import decodePkg::*;

    ctrlT    ctrl;
    regIdxT  rs1;
    regIdxT  rs2;
    regIdxT  rd;
    immFmtT  immFmt;
    wordT    imm;
    wordT    pcNext;
    decodedT next;  // Decoded bundle before the stage register

    ctrlDecoder u_ctrlDecoder (
        .instr  (instr),
        .ctrl   (ctrl),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .immFmt (immFmt)
    );

    immGen u_immGen (
        .instr  (instr),
        .immFmt (immFmt),
        .imm    (imm)
    );

    // Every legal encoding sets at least one control bit
    assign pcNext = (ctrl == '0) ? '0 : pcIn;

    assign next = '{rs1: rs1, rs2: rs2, rd: rd, imm: imm, pc: pcNext, ctrl: ctrl};

    decodeStageReg u_stageReg (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .next    (next),
        .decoded (decoded)
    );

endmodule

/* tbDecodeRef.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

wordT lfsrState = 32'h7abe_7810;

// Galois LFSR stepped once per bit taken
function automatic wordT randBits(int n);
    wordT v;
    logic lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) lfsrState = lfsrState ^ 32'h8020_0003;
        v = {v[30:0], lsb};
    end
    return v;
endfunction

function automatic wordT encR(logic [6:0] f7, regIdxT s2, regIdxT s1, logic [2:0] f3, regIdxT d);
    return {f7, s2, s1, f3, d, opR};
endfunction

function automatic wordT encI(logic [11:0] im, regIdxT s1, logic [2:0] f3, regIdxT d, opcodeT op);
    return {im, s1, f3, d, op};
endfunction

function automatic wordT encS(logic [11:0] im, regIdxT s2, regIdxT s1, logic [2:0] f3);
    return {im[11:5], s2, s1, f3, im[4:0], opStore};
endfunction

function automatic wordT encB(logic [12:0] im, regIdxT s2, regIdxT s1, logic [2:0] f3);
    return {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], opBranch};
endfunction

function automatic wordT encU(logic [19:0] im, regIdxT d, opcodeT op);
    return {im, d, op};
endfunction

function automatic wordT encJ(logic [20:0] im, regIdxT d);
    return {im[20], im[10:1], im[11], im[19:12], d, opJal};
endfunction

function automatic aluOpT expAluOp(logic [2:0] f3, logic b30, logic isR);
    aluOpT t[8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
    if (f3 == 3'd0 && isR && b30) return aluSub;
    if (f3 == 3'd5 && b30) return aluSra;
    return t[f3];
endfunction

// Expected bundle from the decode rules
function automatic decodedT refDecode(wordT ins, wordT pc);
    decodedT d;
    logic [2:0] f3;
    logic [6:0] f7;
    logic sx;
    aluOpT brT[8] = '{aluBeq, aluBne, aluAdd, aluAdd, aluBlt, aluBge, aluBltu, aluBgeu};
    d = '0;
    f3 = ins[14:12];
    f7 = ins[31:25];
    sx = ins[31];
    case (ins[6:0])
        opR: if (f7 == f7Base || (f7 == f7Alt && (f3 == 3'd0 || f3 == 3'd5))) begin
            d.pc = pc;
            d.ctrl.aluOp = expAluOp(f3, ins[30], 1'b1);
            d.ctrl.aluToReg = 1'b1;
            {d.rs1, d.rs2, d.rd} = {ins[19:15], ins[24:20], ins[11:7]};
        end
        opImm: begin
            d.pc = pc;
            d.ctrl.aluOp = expAluOp(f3, ins[30], 1'b0);
            d.ctrl.selB = selBImm;
            d.ctrl.aluToReg = 1'b1;
            {d.rs1, d.rd} = {ins[19:15], ins[11:7]};
            d.imm = (f3 == 3'd1 || f3 == 3'd5) ? {26'b0, ins[25:20]} : {{20{sx}}, ins[31:20]};
        end
        opLoad: if (!(f3 inside {3'd3, 3'd6, 3'd7})) begin
            d.pc = pc;
            d.ctrl.selB = selBImm;
            d.ctrl.memOp = f3[2] ? memReadZext : memReadSext;
            d.ctrl.memSize = memSizeT'(f3[1:0]);
            {d.rs1, d.rd} = {ins[19:15], ins[11:7]};
            d.imm = {{20{sx}}, ins[31:20]};
        end
        opStore: if (f3 < 3'd3) begin
            d.pc = pc;
            d.ctrl.selB = selBImm;
            d.ctrl.memOp = memWrite;
            d.ctrl.memSize = memSizeT'(f3[1:0]);
            {d.rs1, d.rs2} = {ins[19:15], ins[24:20]};
            d.imm = {{20{sx}}, ins[31:25], ins[11:7]};
        end
        opBranch: if (f3 != 3'd2 && f3 != 3'd3) begin
            d.pc = pc;
            d.ctrl.aluOp = brT[f3];
            d.ctrl.branch = 1'b1;
            {d.rs1, d.rs2} = {ins[19:15], ins[24:20]};
            d.imm = {{20{sx}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        opJal, opJalr: if (ins[6:0] == opJal || f3 == 3'd0) begin
            d.pc = pc;
            d.ctrl.selA = 1'b1;
            d.ctrl.selB = selBFour;
            d.ctrl.aluToReg = 1'b1;
            d.rd = ins[11:7];
            if (ins[6:0] == opJal) begin
                d.ctrl.jal = 1'b1;
                d.imm = {{12{sx}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end else begin
                d.ctrl.jalr = 1'b1;
                d.rs1 = ins[19:15];
                d.imm = {{20{sx}}, ins[31:20]};
            end
        end
        opLui, opAuipc: begin
            d.pc = pc;
            d.ctrl.selA = (ins[6:0] == opAuipc);
            d.ctrl.selB = selBImm;
            d.ctrl.aluToReg = 1'b1;
            d.rd = ins[11:7];
            d.imm = {ins[31:12], 12'b0};
        end
        default: ; // Bubble, pc included
    endcase
    return d;
endfunction

`endif

/* tbDecodeStage.sv */
`timescale 1ns/10ps

module tbDecodeStage;
    import decodePkg::*;

    `include "tbDecodeRef.svh"

    localparam int maxCycles = 400; // About 140 cycles of tests plus margin

    logic    clk = 1'b0;
    logic    rstN;
    logic    stall;
    logic    flush;
    wordT    instr;
    wordT    pcIn;
    decodedT decoded;
    int      cycles = 0;

    decodeStage u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .stall   (stall),
        .flush   (flush),
        .instr   (instr),
        .pcIn    (pcIn),
        .decoded (decoded)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout: simulation ran past %0d cycles", maxCycles);
            $display("TB FAILED");
            $fatal(1, "run did not finish");
        end
    end

    task automatic checkEq(logic [127:0] act, logic [127:0] exp, string msg);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s act=%h exp=%h", $time, msg, act, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Drive one instruction, check the output after the capturing edge
    task automatic decodeOne(wordT ins, string msg);
        wordT pc;
        pc = randBits(30) << 2;
        @(posedge clk);
        instr <= ins;
        pcIn  <= pc;
        @(posedge clk);
        @(negedge clk);
        checkEq(decoded, refDecode(ins, pc), msg);
    endtask

    task automatic resetTest();
        repeat (2) @(negedge clk) checkEq(decoded, '0, "bubble in reset");
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkEq(decoded, '0, "bubble after reset");
    endtask

    task automatic aluTest();
        for (int f = 0; f < 8; f++) begin
            decodeOne(encR(f7Base, randBits(5), randBits(5), f, randBits(5)), "R base");
            decodeOne(encI(randBits(12), randBits(5), f, randBits(5), opImm), "I alu");
        end
        decodeOne(encR(f7Alt, randBits(5), randBits(5), f3AddSub, randBits(5)), "SUB");
        decodeOne(encR(f7Alt, randBits(5), randBits(5), f3Sr, randBits(5)), "SRA");
        decodeOne(encI({f7Alt, 5'd13}, randBits(5), f3Sr, randBits(5), opImm), "SRAI");
        decodeOne(encI({f7Base, 5'd31}, randBits(5), f3Sll, randBits(5), opImm), "SLLI");
        decodeOne(encR(f7Alt, randBits(5), randBits(5), f3Xor, randBits(5)), "bad funct7");
        decodeOne(encR(7'h01, randBits(5), randBits(5), f3AddSub, randBits(5)), "MUL");
        decodeOne(encI(randBits(12), 5'd0, 3'd0, 5'd0, opFence), "FENCE");
        decodeOne(encI(12'd1, 5'd0, 3'd0, 5'd0, opSystem), "EBREAK");
    endtask

    task automatic memTest();
        for (int f = 0; f < 8; f++) begin
            decodeOne(encI(randBits(12), randBits(5), f, randBits(5), opLoad), "load");
        end
        for (int f = 0; f < 4; f++) begin
            decodeOne(encS(randBits(12), randBits(5), randBits(5), f), "store");
        end
    endtask

    task automatic ctrlFlowTest();
        for (int f = 0; f < 8; f++) begin
            decodeOne(encB(randBits(13), randBits(5), randBits(5), f), "branch");
        end
        decodeOne(encJ(randBits(21), randBits(5)), "JAL");
        decodeOne(encI(randBits(12), randBits(5), 3'd0, randBits(5), opJalr), "JALR");
        decodeOne(encI(randBits(12), randBits(5), 3'd1, randBits(5), opJalr), "bad JALR");
        decodeOne(encU(randBits(20), randBits(5), opLui), "LUI");
        decodeOne(encU(randBits(20), randBits(5), opAuipc), "AUIPC");
    endtask

    task automatic stallTest();
        decodedT held;
        wordT ins;
        wordT pc;
        ins  = encR(f7Base, 5'd3, 5'd4, f3Or, 5'd5);
        pc   = randBits(30) << 2;
        held = refDecode(ins, pc);
        @(posedge clk);
        instr <= ins;
        pcIn  <= pc;
        @(posedge clk);
        @(negedge clk);
        checkEq(decoded, held, "before stall");
        for (int i = 0; i < 3; i++) begin
            ins = encI(randBits(12), randBits(5), 3'd0, randBits(5), opImm);
            @(posedge clk);
            stall <= 1'b1;
            instr <= ins;
            @(negedge clk);
            if (i > 0) checkEq(decoded, held, "stall hold");
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        checkEq(decoded, held, "last stalled edge");
        @(posedge clk);
        @(negedge clk);
        checkEq(decoded, refDecode(ins, pc), "instruction waiting in stall");
        decodeOne(encU(randBits(20), randBits(5), opLui), "after stall");
    endtask

    task automatic flushTest();
        decodeOne(encJ(randBits(21), 5'd1), "before flush");
        @(posedge clk);
        flush <= 1'b1;
        instr <= encU(20'h12345, 5'd2, opLui);
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b1; // Must not consume the discard
        @(negedge clk);
        checkEq(decoded, '0, "flush bubble");
        @(posedge clk);
        stall <= 1'b0;
        instr <= encU(20'h54321, 5'd3, opAuipc);
        @(negedge clk);
        checkEq(decoded, '0, "stall after flush");
        @(posedge clk);
        @(negedge clk);
        checkEq(decoded, '0, "discarded instruction");
        decodeOne(encI(randBits(12), randBits(5), 3'd2, randBits(5), opLoad), "after discard");
    endtask

    initial begin
        rstN  = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        instr = '0;
        pcIn  = '0;
        resetTest();
        aluTest();
        memTest();
        ctrlFlowTest();
        stallTest();
        flushTest();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
decodePkg.sv
immGen.sv
ctrlDecoder.sv
decodeStageReg.sv
decodeStage.sv
tbDecodeStage.sv
